/* core_params.svh */
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// Datapath word width
`define CORE_DATA_W 32

// Architectural registers
`define CORE_NREGS 32

// Reorder buffer entries also set the tag width
`define CORE_ROB_DEPTH 8

// Entries per reservation station
`define CORE_STATION_DEPTH 2

// Multiplier pipeline stages
`define CORE_MUL_LATENCY 3

`endif

/* core_pkg.sv */
`include "core_params.svh"

package core_pkg;

   // Instruction field positions
   localparam int OPC_W = 6;
   localparam int OPC_LSB = 26;
   localparam int RD_LSB = 21;
   localparam int RS1_LSB = 16;
   localparam int RS2_LSB = 11;
   localparam int IMM_W = 16;

   typedef logic [`CORE_DATA_W-1:0] word_t;
   typedef logic [$clog2(`CORE_NREGS)-1:0] reg_idx_t;
   typedef logic [$clog2(`CORE_ROB_DEPTH)-1:0] tag_t;

   typedef enum logic [OPC_W-1:0] {
      OP_ADD  = 6'h01,
      OP_SUB  = 6'h02,
      OP_AND  = 6'h03,
      OP_OR   = 6'h04,
      OP_XOR  = 6'h05,
      OP_ADDI = 6'h06,
      OP_MUL  = 6'h07
   } opcode_e;

   // Value is valid only when filled, else wait for tag
   typedef struct packed {
      word_t value;
      tag_t tag;
      logic filled;
   } operand_t;

   typedef struct packed {
      tag_t dst;
      opcode_e op;
      operand_t a;
      operand_t b;
   } issue_t;

   typedef struct packed {
      tag_t tag;
      word_t data;
   } cdb_t;

endpackage

/* core_if.sv */
interface issue_if;
   import core_pkg::*;

   logic valid;
   logic ready;
   issue_t data;

   modport source (output valid, output data, input ready);
   modport sink (input valid, input data, output ready);
endinterface

interface cdb_if;
   import core_pkg::*;

   // req and grant per unit, valid on the shared bus
   logic req;
   logic grant;
   logic valid;
   cdb_t data;

   modport unit (output req, output data, input grant);
   modport arbiter (input req, input data, output grant);
   modport broadcast (output valid, output data);
   modport monitor (input valid, input data);
endinterface

/* dispatch.sv */
module dispatch (
   input logic i_instr_valid,
   input core_pkg::word_t i_instr,
   output logic o_instr_ready,
   output core_pkg::reg_idx_t o_rf_rd_a,
   output core_pkg::reg_idx_t o_rf_rd_b,
   input core_pkg::operand_t i_rf_a,
   input core_pkg::operand_t i_rf_b,
   output logic o_rf_rename,
   output core_pkg::reg_idx_t o_rf_rename_reg,
   output logic o_rob_alloc,
   input core_pkg::tag_t i_rob_tag,
   input logic i_rob_full,
   output core_pkg::tag_t o_rob_query_a,
   output core_pkg::tag_t o_rob_query_b,
   input core_pkg::operand_t i_rob_a,
   input core_pkg::operand_t i_rob_b,
   cdb_if.monitor cdb,
   issue_if.source alu_issue,
   issue_if.source mul_issue
);
   import core_pkg::*;

   opcode_e opcode;
   logic [IMM_W-1:0] imm;
   operand_t opnd_a;
   operand_t opnd_b;
   issue_t entry;
   logic is_mul;
   logic fire;

   // Bus hit first, then register, then ROB
   function automatic operand_t resolve(operand_t rf, operand_t rob, logic bus_valid, cdb_t bus);
      operand_t res;
      if (!rf.filled && bus_valid && bus.tag == rf.tag) begin
         res.value = bus.data;
         res.tag = bus.tag;
         res.filled = 1'b1;
      end else if (rf.filled) begin
         res = rf;
      end else begin
         res = rob;
      end
      return res;
   endfunction

   assign opcode = opcode_e'(i_instr[OPC_LSB +: OPC_W]);
   assign imm = i_instr[IMM_W-1:0];
   assign is_mul = (opcode == OP_MUL);

   assign o_rf_rd_a = i_instr[RS1_LSB +: $bits(reg_idx_t)];
   assign o_rf_rd_b = i_instr[RS2_LSB +: $bits(reg_idx_t)];
   assign o_rob_query_a = i_rf_a.tag;
   assign o_rob_query_b = i_rf_b.tag;

   assign opnd_a = resolve(i_rf_a, i_rob_a, cdb.valid, cdb.data);

   always_comb begin
      if (opcode == OP_ADDI) begin
         opnd_b.value = {{($bits(word_t) - IMM_W){imm[IMM_W-1]}}, imm};
         opnd_b.tag = '0;
         opnd_b.filled = 1'b1;
      end else begin
         opnd_b = resolve(i_rf_b, i_rob_b, cdb.valid, cdb.data);
      end
   end

   assign o_instr_ready = !i_rob_full && (is_mul ? mul_issue.ready : alu_issue.ready);
   assign fire = i_instr_valid && o_instr_ready;

   assign entry.dst = i_rob_tag;
   assign entry.op = opcode;
   assign entry.a = opnd_a;
   assign entry.b = opnd_b;

   assign o_rob_alloc = fire;
   assign o_rf_rename = fire;
   assign o_rf_rename_reg = i_instr[RD_LSB +: $bits(reg_idx_t)];

   assign alu_issue.valid = fire && !is_mul;
   assign alu_issue.data = entry;
   assign mul_issue.valid = fire && is_mul;
   assign mul_issue.data = entry;

endmodule

/* register_file.sv */
`include "core_params.svh"

module register_file (
   input logic clk,
   input logic nrst,
   input core_pkg::reg_idx_t i_rd_a,
   input core_pkg::reg_idx_t i_rd_b,
   output core_pkg::operand_t o_rd_a,
   output core_pkg::operand_t o_rd_b,
   input logic i_rename,
   input core_pkg::reg_idx_t i_rename_reg,
   input core_pkg::tag_t i_rename_tag,
   input logic i_commit_valid,
   input core_pkg::reg_idx_t i_commit_reg,
   input core_pkg::tag_t i_commit_tag,
   input core_pkg::word_t i_commit_data
);
   import core_pkg::*;

   localparam int NREGS = `CORE_NREGS;

   word_t reg_value [NREGS];
   tag_t reg_tag [NREGS];
   logic [NREGS-1:0] busy;

   // Not busy means the value is architectural
   always_comb begin
      o_rd_a.value = reg_value[i_rd_a];
      o_rd_a.tag = reg_tag[i_rd_a];
      o_rd_a.filled = !busy[i_rd_a];
      o_rd_b.value = reg_value[i_rd_b];
      o_rd_b.tag = reg_tag[i_rd_b];
      o_rd_b.filled = !busy[i_rd_b];
   end

   always_ff @(posedge clk) begin
      if (nrst) begin
         busy <= '0;
         for (int i = 0; i < NREGS; i++) begin
            reg_value[i] <= '0;
            reg_tag[i] <= '0;
         end
      end else begin
         if (i_commit_valid) begin
            reg_value[i_commit_reg] <= i_commit_data;
            // Younger producer keeps the register busy
            if (reg_tag[i_commit_reg] == i_commit_tag) begin
               busy[i_commit_reg] <= 1'b0;
            end
         end
         if (i_rename) begin
            busy[i_rename_reg] <= 1'b1;
            reg_tag[i_rename_reg] <= i_rename_tag;
         end
      end
   end

endmodule

/* reorder_buffer.sv */
`include "core_params.svh"

module reorder_buffer (
   input logic clk,
   input logic nrst,
   input logic i_alloc,
   output core_pkg::tag_t o_tag,
   output logic o_full,
   input core_pkg::reg_idx_t i_dst_reg,
   input core_pkg::tag_t i_query_a,
   input core_pkg::tag_t i_query_b,
   output core_pkg::operand_t o_query_a,
   output core_pkg::operand_t o_query_b,
   cdb_if.monitor cdb,
   output logic o_commit_valid,
   output core_pkg::reg_idx_t o_commit_reg,
   output core_pkg::tag_t o_commit_tag,
   output core_pkg::word_t o_commit_data
);
   import core_pkg::*;

   localparam int DEPTH = `CORE_ROB_DEPTH;
   localparam int CNT_W = $clog2(DEPTH + 1);

   reg_idx_t dst_reg [DEPTH];
   word_t value [DEPTH];
   logic [DEPTH-1:0] done;
   tag_t head;
   tag_t tail;
   logic [CNT_W-1:0] count;

   assign o_tag = tail;
   assign o_full = (count == CNT_W'(DEPTH));

   // Head retires once its result is back
   assign o_commit_valid = (count != '0) && done[head];
   assign o_commit_reg = dst_reg[head];
   assign o_commit_tag = head;
   assign o_commit_data = value[head];

   always_comb begin
      o_query_a.value = value[i_query_a];
      o_query_a.tag = i_query_a;
      o_query_a.filled = done[i_query_a];
      o_query_b.value = value[i_query_b];
      o_query_b.tag = i_query_b;
      o_query_b.filled = done[i_query_b];
   end

   always_ff @(posedge clk) begin
      if (nrst) begin
         head <= '0;
         tail <= '0;
         count <= '0;
         done <= '0;
      end else begin
         if (i_alloc) begin
            done[tail] <= 1'b0;
            tail <= tail + 1'b1;
         end
         if (cdb.valid) begin
            done[cdb.data.tag] <= 1'b1;
         end
         if (o_commit_valid) begin
            head <= head + 1'b1;
         end
         count <= count + CNT_W'(i_alloc) - CNT_W'(o_commit_valid);
      end
   end

   always_ff @(posedge clk) begin
      if (i_alloc) begin
         dst_reg[tail] <= i_dst_reg;
      end
      if (cdb.valid) begin
         value[cdb.data.tag] <= cdb.data.data;
      end
   end

endmodule

/* exec_unit.sv */
`include "core_params.svh"

module exec_unit #(
   parameter int LATENCY = 1
) (
   input logic clk,
   input logic nrst,
   issue_if.sink issue,
   cdb_if.unit cdb_out,
   cdb_if.monitor cdb
);
   import core_pkg::*;

   localparam int DEPTH = `CORE_STATION_DEPTH;
   localparam int SEL_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

   // Station kept in age order with the oldest at index 0
   logic [DEPTH-1:0] st_valid;
   logic [DEPTH-1:0] nxt_valid;
   issue_t st_entry [DEPTH];
   issue_t nxt_entry [DEPTH];
   logic [SEL_W-1:0] sel;
   logic found;
   logic do_issue;
   logic placed;
   logic stall;

   logic [LATENCY-1:0] pipe_valid;
   cdb_t pipe_data [LATENCY];

   function automatic word_t compute(issue_t e);
      case (e.op)
         OP_ADD, OP_ADDI: return e.a.value + e.b.value;
         OP_SUB: return e.a.value - e.b.value;
         OP_AND: return e.a.value & e.b.value;
         OP_OR: return e.a.value | e.b.value;
         OP_XOR: return e.a.value ^ e.b.value;
         OP_MUL: return e.a.value * e.b.value;
         default: return '0;
      endcase
   endfunction

   assign issue.ready = !st_valid[DEPTH-1];
   assign cdb_out.req = pipe_valid[LATENCY-1];
   assign cdb_out.data = pipe_data[LATENCY-1];
   // Whole pipeline holds while the last stage waits for the bus
   assign stall = pipe_valid[LATENCY-1] && !cdb_out.grant;
   assign do_issue = found && !stall;

   always_comb begin
      found = 1'b0;
      sel = '0;
      for (int i = DEPTH - 1; i >= 0; i--) begin
         if (st_valid[i] && st_entry[i].a.filled && st_entry[i].b.filled) begin
            found = 1'b1;
            sel = SEL_W'(i);
         end
      end
   end

   always_comb begin
      nxt_valid = st_valid;
      nxt_entry = st_entry;
      placed = 1'b0;
      for (int i = 0; i < DEPTH; i++) begin
         if (cdb.valid && !nxt_entry[i].a.filled && nxt_entry[i].a.tag == cdb.data.tag) begin
            nxt_entry[i].a.value = cdb.data.data;
            nxt_entry[i].a.filled = 1'b1;
         end
         if (cdb.valid && !nxt_entry[i].b.filled && nxt_entry[i].b.tag == cdb.data.tag) begin
            nxt_entry[i].b.value = cdb.data.data;
            nxt_entry[i].b.filled = 1'b1;
         end
      end
      // Close the gap left by the issued entry
      if (do_issue) begin
         for (int i = 0; i < DEPTH - 1; i++) begin
            if (i >= int'(sel)) begin
               nxt_valid[i] = nxt_valid[i + 1];
               nxt_entry[i] = nxt_entry[i + 1];
            end
         end
         nxt_valid[DEPTH-1] = 1'b0;
      end
      if (issue.valid && issue.ready) begin
         for (int i = 0; i < DEPTH; i++) begin
            if (!nxt_valid[i] && !placed) begin
               nxt_valid[i] = 1'b1;
               nxt_entry[i] = issue.data;
               placed = 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (nrst) begin
         st_valid <= '0;
         pipe_valid <= '0;
      end else begin
         st_valid <= nxt_valid;
         if (!stall) begin
            pipe_valid[0] <= do_issue;
            for (int i = 1; i < LATENCY; i++) begin
               pipe_valid[i] <= pipe_valid[i - 1];
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      st_entry <= nxt_entry;
      if (!stall) begin
         pipe_data[0].tag <= st_entry[sel].dst;
         pipe_data[0].data <= compute(st_entry[sel]);
         for (int i = 1; i < LATENCY; i++) begin
            pipe_data[i] <= pipe_data[i - 1];
         end
      end
   end

endmodule

/* cdb_arbiter.sv */
module cdb_arbiter (
   cdb_if.arbiter alu_req,
   cdb_if.arbiter mul_req,
   cdb_if.broadcast cdb
);

   // Multiplier wins since its pipeline is the deeper one to stall
   assign mul_req.grant = mul_req.req;
   assign alu_req.grant = alu_req.req && !mul_req.req;

   assign cdb.valid = alu_req.req || mul_req.req;

   always_comb begin
      if (mul_req.req) begin
         cdb.data = mul_req.data;
      end else begin
         cdb.data = alu_req.data;
      end
   end

endmodule

/* ooo_core.sv */
`include "core_params.svh"

module ooo_core (
   input logic clk,
   input logic nrst,
   input logic i_instr_valid,
   input core_pkg::word_t i_instr,
   output logic o_instr_ready,
   output logic o_commit_valid,
   output core_pkg::reg_idx_t o_commit_reg,
   output core_pkg::word_t o_commit_data
);
   import core_pkg::*;

   reg_idx_t rd_a;
   reg_idx_t rd_b;
   reg_idx_t rename_reg;
   operand_t rf_a;
   operand_t rf_b;
   operand_t rob_a;
   operand_t rob_b;
   tag_t query_a;
   tag_t query_b;
   tag_t rob_tag;
   tag_t commit_tag;
   logic rename;
   logic rob_alloc;
   logic rob_full;

   issue_if alu_issue ();
   issue_if mul_issue ();
   cdb_if alu_cdb ();
   cdb_if mul_cdb ();
   cdb_if bus ();

   dispatch dispatch_i (
      .i_instr_valid(i_instr_valid),
      .i_instr(i_instr),
      .o_instr_ready(o_instr_ready),
      .o_rf_rd_a(rd_a),
      .o_rf_rd_b(rd_b),
      .i_rf_a(rf_a),
      .i_rf_b(rf_b),
      .o_rf_rename(rename),
      .o_rf_rename_reg(rename_reg),
      .o_rob_alloc(rob_alloc),
      .i_rob_tag(rob_tag),
      .i_rob_full(rob_full),
      .o_rob_query_a(query_a),
      .o_rob_query_b(query_b),
      .i_rob_a(rob_a),
      .i_rob_b(rob_b),
      .cdb(bus),
      .alu_issue(alu_issue),
      .mul_issue(mul_issue)
   );

   register_file register_file_i (
      .clk(clk),
      .nrst(nrst),
      .i_rd_a(rd_a),
      .i_rd_b(rd_b),
      .o_rd_a(rf_a),
      .o_rd_b(rf_b),
      .i_rename(rename),
      .i_rename_reg(rename_reg),
      .i_rename_tag(rob_tag),
      .i_commit_valid(o_commit_valid),
      .i_commit_reg(o_commit_reg),
      .i_commit_tag(commit_tag),
      .i_commit_data(o_commit_data)
   );

   reorder_buffer reorder_buffer_i (
      .clk(clk),
      .nrst(nrst),
      .i_alloc(rob_alloc),
      .o_tag(rob_tag),
      .o_full(rob_full),
      .i_dst_reg(rename_reg),
      .i_query_a(query_a),
      .i_query_b(query_b),
      .o_query_a(rob_a),
      .o_query_b(rob_b),
      .cdb(bus),
      .o_commit_valid(o_commit_valid),
      .o_commit_reg(o_commit_reg),
      .o_commit_tag(commit_tag),
      .o_commit_data(o_commit_data)
   );

   exec_unit #(
      .LATENCY(1)
   ) alu_unit_i (
      .clk(clk),
      .nrst(nrst),
      .issue(alu_issue),
      .cdb_out(alu_cdb),
      .cdb(bus)
   );

   exec_unit #(
      .LATENCY(`CORE_MUL_LATENCY)
   ) mul_unit_i (
      .clk(clk),
      .nrst(nrst),
      .issue(mul_issue),
      .cdb_out(mul_cdb),
      .cdb(bus)
   );

   cdb_arbiter cdb_arbiter_i (
      .alu_req(alu_cdb),
      .mul_req(mul_cdb),
      .cdb(bus)
   );

endmodule

/* ooo_core_asserts.sv */
`include "core_params.svh"

module ooo_core_asserts (
   input logic clk,
   input logic nrst,
   input logic [$clog2(`CORE_ROB_DEPTH + 1)-1:0] i_rob_count,
   input logic i_alu_grant,
   input logic i_mul_grant,
   input logic i_commit_valid
);
   timeunit 1ns;
   timeprecision 1ps;

   localparam int ROB_DEPTH = `CORE_ROB_DEPTH;
   localparam int CNT_W = $clog2(ROB_DEPTH + 1);

   rob_count_bound: assert property (@(posedge clk) disable iff (nrst)
      i_rob_count <= CNT_W'(ROB_DEPTH))
      else $error("ROB count %0d above depth", i_rob_count);

   single_grant: assert property (@(posedge clk) disable iff (nrst)
      !(i_alu_grant && i_mul_grant))
      else $error("ALU and multiplier granted the bus together");

   // First cycle out of reset
   quiet_after_reset: assert property (@(posedge clk) $fell(nrst) |-> !i_commit_valid)
      else $error("Commit valid high right after reset");

endmodule

bind ooo_core ooo_core_asserts ooo_core_asserts_i (
   .clk(clk),
   .nrst(nrst),
   .i_rob_count(reorder_buffer_i.count),
   .i_alu_grant(alu_cdb.grant),
   .i_mul_grant(mul_cdb.grant),
   .i_commit_valid(o_commit_valid)
);

/* tb_ooo_core.sv */
`include "core_params.svh"

module tb_ooo_core;
   timeunit 1ns;
   timeprecision 1ps;
   import core_pkg::*;

   localparam int NUM_RANDOM = 30;

   typedef struct packed {
      opcode_e op;
      reg_idx_t rd;
      reg_idx_t rs1;
      reg_idx_t rs2;
      logic [15:0] imm;
      word_t exp_data;
   } row_t;

   logic clk;
   logic nrst;
   logic i_instr_valid;
   word_t i_instr;
   logic o_instr_ready;
   logic o_commit_valid;
   reg_idx_t o_commit_reg;
   word_t o_commit_data;

   row_t rows [$];
   reg_idx_t exp_reg_q [$];
   word_t exp_data_q [$];
   word_t model_regs [`CORE_NREGS];
   int error_count = 0;
   int check_count = 0;
   int accept_count = 0;
   int commit_count = 0;
   int stall_cycles = 0;
   int mul_first = 0;
   int mul_last = 0;
   int timeout_cycles = 0;
   logic table_ready = 1'b0;

   ooo_core ooo_core_i (
      .clk(clk),
      .nrst(nrst),
      .i_instr_valid(i_instr_valid),
      .i_instr(i_instr),
      .o_instr_ready(o_instr_ready),
      .o_commit_valid(o_commit_valid),
      .o_commit_reg(o_commit_reg),
      .o_commit_data(o_commit_data)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   task automatic compare_reg(reg_idx_t got, reg_idx_t exp, string what);
      check_count++;
      if (got !== exp) begin
         error_count++;
         $display("Error at time %0t: %s is r%0d, expected r%0d", $time, what, got, exp);
      end
   endtask

   task automatic compare_word(word_t got, word_t exp, string what);
      check_count++;
      if (got !== exp) begin
         error_count++;
         $display("Error at time %0t: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic compare_bit(logic got, logic exp, string what);
      check_count++;
      if (got !== exp) begin
         error_count++;
         $display("Error at time %0t: %s is %b, expected %b", $time, what, got, exp);
      end
   endtask

   // Instruction word per the fixed field layout
   function automatic word_t encode(row_t r);
      word_t w;
      w = '0;
      w[31:26] = r.op;
      w[25:21] = r.rd;
      w[20:16] = r.rs1;
      if (r.op == OP_ADDI) begin
         w[15:0] = r.imm;
      end else begin
         w[15:11] = r.rs2;
      end
      return w;
   endfunction

   function automatic word_t model_exec(opcode_e op, word_t a, word_t b, logic [15:0] imm);
      case (op)
         OP_ADD: return a + b;
         OP_SUB: return a - b;
         OP_AND: return a & b;
         OP_OR: return a | b;
         OP_XOR: return a ^ b;
         OP_ADDI: return a + {{16{imm[15]}}, imm};
         // Low half of the product
         OP_MUL: return a * b;
         default: return '0;
      endcase
   endfunction

   task automatic add_row(opcode_e op, reg_idx_t rd, reg_idx_t rs1, reg_idx_t rs2,
                          logic [15:0] imm);
      row_t r;
      r.op = op;
      r.rd = rd;
      r.rs1 = rs1;
      r.rs2 = rs2;
      r.imm = imm;
      r.exp_data = model_exec(op, model_regs[rs1], model_regs[rs2], imm);
      model_regs[rd] = r.exp_data;
      rows.push_back(r);
   endtask

   task automatic build_rows();
      reg_idx_t rd;
      reg_idx_t rs1;
      reg_idx_t rs2;
      opcode_e op;
      for (int i = 0; i < `CORE_NREGS; i++) begin
         model_regs[i] = '0;
      end
      // Independent ALU work
      add_row(OP_ADDI, 5'd1, 5'd0, 5'd0, 16'h0064);
      add_row(OP_ADDI, 5'd2, 5'd0, 5'd0, 16'hfff9);
      add_row(OP_ADDI, 5'd3, 5'd0, 5'd0, 16'h1234);
      add_row(OP_ADD, 5'd4, 5'd1, 5'd3, 16'h0);
      add_row(OP_SUB, 5'd5, 5'd3, 5'd1, 16'h0);
      add_row(OP_AND, 5'd6, 5'd1, 5'd3, 16'h0);
      add_row(OP_OR, 5'd7, 5'd2, 5'd3, 16'h0);
      add_row(OP_XOR, 5'd8, 5'd1, 5'd2, 16'h0);
      add_row(OP_ADDI, 5'd9, 5'd3, 5'd0, 16'hfed4);
      // Dependent chain
      add_row(OP_ADD, 5'd10, 5'd1, 5'd2, 16'h0);
      add_row(OP_SUB, 5'd10, 5'd10, 5'd3, 16'h0);
      add_row(OP_XOR, 5'd11, 5'd10, 5'd1, 16'h0);
      add_row(OP_ADDI, 5'd11, 5'd11, 5'd0, 16'hffff);
      add_row(OP_OR, 5'd12, 5'd11, 5'd10, 16'h0);
      add_row(OP_AND, 5'd12, 5'd12, 5'd3, 16'h0);
      add_row(OP_ADD, 5'd13, 5'd12, 5'd12, 16'h0);
      // MUL overtaken by the ALU
      add_row(OP_MUL, 5'd14, 5'd1, 5'd3, 16'h0);
      add_row(OP_ADD, 5'd15, 5'd1, 5'd1, 16'h0);
      add_row(OP_SUB, 5'd16, 5'd3, 5'd2, 16'h0);
      add_row(OP_XOR, 5'd17, 5'd2, 5'd3, 16'h0);
      add_row(OP_ADD, 5'd18, 5'd14, 5'd15, 16'h0);
      // Chained MULs back up the station
      add_row(OP_ADDI, 5'd20, 5'd0, 5'd0, 16'h0003);
      mul_first = rows.size();
      for (int i = 0; i < 12; i++) begin
         add_row(OP_MUL, 5'd20, 5'd20, (i % 2 == 0) ? 5'd2 : 5'd3, 16'h0);
      end
      // Finished ALU work waits behind the last MULs until the ROB is full
      for (int i = 0; i < 8; i++) begin
         add_row(OP_ADDI, reg_idx_t'(21 + i), 5'd0, 5'd0, 16'(i + 1));
      end
      mul_last = rows.size() - 1;
      for (int i = 0; i < NUM_RANDOM; i++) begin
         op = opcode_e'(6'(1 + $urandom_range(6)));
         rd = reg_idx_t'(1 + $urandom_range(5));
         rs1 = reg_idx_t'(1 + $urandom_range(5));
         rs2 = reg_idx_t'(1 + $urandom_range(5));
         add_row(op, rd, rs1, rs2, 16'($urandom));
      end
   endtask

   always @(negedge clk) begin
      if (!nrst && o_commit_valid) begin
         commit_count++;
         if (exp_data_q.size() == 0) begin
            error_count++;
            $display("Unexpected commit at time %0t with nothing outstanding", $time);
         end else begin
            compare_reg(o_commit_reg, exp_reg_q.pop_front(), "commit register");
            compare_word(o_commit_data, exp_data_q.pop_front(), "commit data");
         end
      end
   end

   initial begin
      wait (table_ready);
      repeat (timeout_cycles) @(posedge clk);
      $display("Timeout: run did not finish within %0d cycles", timeout_cycles);
      $display("TEST FAILED");
      $finish;
   end

   initial begin
      logic accepted;
      void'($urandom(32'h30dc_801f));
      nrst = 1'b1;
      i_instr_valid = 1'b0;
      i_instr = '0;
      build_rows();
      timeout_cycles = rows.size() * 20 + 200;
      table_ready = 1'b1;
      repeat (3) @(posedge clk);
      #2 nrst = 1'b0;

      @(negedge clk);
      compare_bit(o_commit_valid, 1'b0, "commit valid after reset");
      compare_bit(o_instr_ready, 1'b1, "instr ready after reset");
      @(posedge clk);
      #2;

      for (int i = 0; i < rows.size(); i++) begin
         i_instr = encode(rows[i]);
         i_instr_valid = 1'b1;
         accepted = 1'b0;
         while (!accepted) begin
            @(negedge clk);
            if (o_instr_ready) begin
               accepted = 1'b1;
               exp_reg_q.push_back(rows[i].rd);
               exp_data_q.push_back(rows[i].exp_data);
               accept_count++;
            end else if (i >= mul_first && i <= mul_last) begin
               stall_cycles++;
            end
            @(posedge clk);
            #2;
         end
      end
      i_instr_valid = 1'b0;

      while (exp_data_q.size() != 0) begin
         @(posedge clk);
      end
      repeat (10) @(posedge clk);

      if (commit_count != accept_count) begin
         error_count++;
         $display("Commit count %0d does not match accepted count %0d",
                  commit_count, accept_count);
      end
      if (stall_cycles == 0) begin
         error_count++;
         $display("Instruction ready never dropped during the MUL run");
      end

      $display("Checks: %0d, errors: %0d, accepted: %0d, committed: %0d",
               check_count, error_count, accept_count, commit_count);
      if (error_count == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

/* ooo_core.f */
+incdir+.
core_pkg.sv
core_if.sv
dispatch.sv
register_file.sv
reorder_buffer.sv
exec_unit.sv
cdb_arbiter.sv
ooo_core.sv
ooo_core_asserts.sv
tb_ooo_core.sv

/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
TOP = tb_ooo_core
FILELIST = ooo_core.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf obj_dir
